/* lc4_dual.f */
src/lc4_pkg.sv
src/lc4_alu.sv
src/lc4_issue.sv
src/lc4_lane.sv
src/lc4_regfile.sv
src/lc4_dual_top.sv
tests/lc4_retire_checker.sv
tests/tb_lc4_dual.sv

/* src/lc4_alu.sv */
//////////////////////////////////////////////////////////////////////
// ALU for the kept LC4 subset, purely combinational
// results wrap at 16 bits, MUL keeps the low half
// unsupported encodings return zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lc4_alu (
    input  logic [lc4_pkg::LC4_WORD_W-1:0] i_insn,
    input  logic [lc4_pkg::LC4_WORD_W-1:0] i_rs_data,
    input  logic [lc4_pkg::LC4_WORD_W-1:0] i_rt_data,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_result
);
    import lc4_pkg::*;

    lc4_insn_u             insn;
    logic [LC4_WORD_W-1:0] imm5_sx;
    logic [LC4_WORD_W-1:0] imm9_sx;

    assign insn    = i_insn;
    assign imm5_sx = {{(LC4_WORD_W-5){insn.i.imm5[4]}}, insn.i.imm5};
    assign imm9_sx = {{(LC4_WORD_W-9){insn.c.imm9[8]}}, insn.c.imm9};

    always_comb begin
        o_result = '0;
        case (insn.r.opcode)
            LC4_OP_ARITH: begin
                if (insn.i.imm) o_result = i_rs_data + imm5_sx;
                else begin
                    case (insn.r.sub)
                        LC4_SUB_ADD: o_result = i_rs_data + i_rt_data;
                        LC4_SUB_MUL: o_result = i_rs_data * i_rt_data;   // low 16 bits
                        LC4_SUB_SUB: o_result = i_rs_data - i_rt_data;
                        default:     o_result = '0;                      // DIV dropped
                    endcase
                end
            end
            LC4_OP_LOGIC: begin
                if (insn.i.imm) o_result = i_rs_data & imm5_sx;
                else begin
                    case (insn.r.sub)
                        LC4_SUB_AND: o_result = i_rs_data & i_rt_data;
                        LC4_SUB_NOT: o_result = ~i_rs_data;
                        LC4_SUB_OR:  o_result = i_rs_data | i_rt_data;
                        default:     o_result = i_rs_data ^ i_rt_data;   // XOR
                    endcase
                end
            end
            LC4_OP_CONST: o_result = imm9_sx;
            default:      o_result = '0;
        endcase
    end

endmodule

/* src/lc4_dual_top.sv */
//////////////////////////////////////////////////////////////////////
// two-way LC4 ALU pipeline top level
// instruction memory sits outside and must return the words at
// o_cur_pc and o_cur_pc+1 combinationally. retire ports show the
// writeback stage, lane A is older than lane B in the same cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lc4_dual_top (
    input  logic                          gwe,
    input  logic                          i_arst_n,
    input  logic [lc4_pkg::LC4_WORD_W-1:0] i_cur_insn_a,
    input  logic [lc4_pkg::LC4_WORD_W-1:0] i_cur_insn_b,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_cur_pc,
    output logic                          o_wb_valid_a,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_wb_pc_a,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_wb_insn_a,
    output logic                          o_wb_we_a,
    output logic [lc4_pkg::LC4_REG_W-1:0]  o_wb_wsel_a,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_wb_data_a,
    output logic                          o_wb_valid_b,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_wb_pc_b,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_wb_insn_b,
    output logic                          o_wb_we_b,
    output logic [lc4_pkg::LC4_REG_W-1:0]  o_wb_wsel_b,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_wb_data_b
);
    import lc4_pkg::*;

    logic [LC4_REG_W-1:0]  rs_a, rt_a, rs_b, rt_b;
    logic [LC4_WORD_W-1:0] rs_data_a, rt_data_a, rs_data_b, rt_data_b;
    logic                  x_valid_a, x_we_a, x_valid_b, x_we_b;
    logic [LC4_WORD_W-1:0] x_pc_a, x_insn_a, x_pc_b, x_insn_b;
    logic [LC4_REG_W-1:0]  x_rd_a, x_rd_b;
    logic                  m_we_a, m_we_b;    // memory-stage bypass sources
    logic [LC4_REG_W-1:0]  m_rd_a, m_rd_b;
    logic [LC4_WORD_W-1:0] m_data_a, m_data_b;

    lc4_issue u_issue (
        .gwe, .i_arst_n,
        .i_insn_a (i_cur_insn_a), .i_insn_b (i_cur_insn_b), .o_fetch_pc (o_cur_pc),
        .o_rs_a (rs_a), .o_rt_a (rt_a), .o_rs_b (rs_b), .o_rt_b (rt_b),
        .o_x_valid_a (x_valid_a), .o_x_pc_a (x_pc_a), .o_x_insn_a (x_insn_a),
        .o_x_rd_a (x_rd_a), .o_x_we_a (x_we_a),
        .o_x_valid_b (x_valid_b), .o_x_pc_b (x_pc_b), .o_x_insn_b (x_insn_b),
        .o_x_rd_b (x_rd_b), .o_x_we_b (x_we_b)
    );

    lc4_regfile u_regfile (
        .gwe, .i_arst_n,
        .i_rs_a (rs_a), .i_rt_a (rt_a), .i_rs_b (rs_b), .i_rt_b (rt_b),
        .i_we_a (o_wb_we_a), .i_rd_a (o_wb_wsel_a), .i_wdata_a (o_wb_data_a),
        .i_we_b (o_wb_we_b), .i_rd_b (o_wb_wsel_b), .i_wdata_b (o_wb_data_b),
        .o_rs_data_a (rs_data_a), .o_rt_data_a (rt_data_a),
        .o_rs_data_b (rs_data_b), .o_rt_data_b (rt_data_b)
    );

    lc4_lane u_lane_a (
        .gwe, .i_arst_n,
        .i_x_valid (x_valid_a), .i_x_pc (x_pc_a), .i_x_insn (x_insn_a),
        .i_x_rd (x_rd_a), .i_x_we (x_we_a), .i_rs_data (rs_data_a), .i_rt_data (rt_data_a),
        .i_mb_we (m_we_b), .i_mb_rd (m_rd_b), .i_mb_data (m_data_b),
        .i_ma_we (m_we_a), .i_ma_rd (m_rd_a), .i_ma_data (m_data_a),
        .i_wb_we (o_wb_we_b), .i_wb_rd (o_wb_wsel_b), .i_wb_data (o_wb_data_b),
        .i_wa_we (o_wb_we_a), .i_wa_rd (o_wb_wsel_a), .i_wa_data (o_wb_data_a),
        .o_m_we (m_we_a), .o_m_rd (m_rd_a), .o_m_data (m_data_a),
        .o_w_valid (o_wb_valid_a), .o_w_pc (o_wb_pc_a), .o_w_insn (o_wb_insn_a),
        .o_w_we (o_wb_we_a), .o_w_rd (o_wb_wsel_a), .o_w_data (o_wb_data_a)
    );

    lc4_lane u_lane_b (
        .gwe, .i_arst_n,
        .i_x_valid (x_valid_b), .i_x_pc (x_pc_b), .i_x_insn (x_insn_b),
        .i_x_rd (x_rd_b), .i_x_we (x_we_b), .i_rs_data (rs_data_b), .i_rt_data (rt_data_b),
        .i_mb_we (m_we_b), .i_mb_rd (m_rd_b), .i_mb_data (m_data_b),
        .i_ma_we (m_we_a), .i_ma_rd (m_rd_a), .i_ma_data (m_data_a),
        .i_wb_we (o_wb_we_b), .i_wb_rd (o_wb_wsel_b), .i_wb_data (o_wb_data_b),
        .i_wa_we (o_wb_we_a), .i_wa_rd (o_wb_wsel_a), .i_wa_data (o_wb_data_a),
        .o_m_we (m_we_b), .o_m_rd (m_rd_b), .o_m_data (m_data_b),
        .o_w_valid (o_wb_valid_b), .o_w_pc (o_wb_pc_b), .o_w_insn (o_wb_insn_b),
        .o_w_we (o_wb_we_b), .o_w_rd (o_wb_wsel_b), .o_w_data (o_wb_data_b)
    );

endmodule

/* src/lc4_issue.sv */
//////////////////////////////////////////////////////////////////////
// fetch PC, decode pair register and pair split
// expects the words at PC and PC+1 back in the same cycle
// a B that reads A's destination is held and replayed in slot A the
// next cycle, fetch then advances by one. no other stall source
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lc4_issue (
    input  logic                          gwe,
    input  logic                          i_arst_n,
    input  logic [lc4_pkg::LC4_WORD_W-1:0] i_insn_a,
    input  logic [lc4_pkg::LC4_WORD_W-1:0] i_insn_b,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_fetch_pc,
    output logic [lc4_pkg::LC4_REG_W-1:0]  o_rs_a,
    output logic [lc4_pkg::LC4_REG_W-1:0]  o_rt_a,
    output logic [lc4_pkg::LC4_REG_W-1:0]  o_rs_b,
    output logic [lc4_pkg::LC4_REG_W-1:0]  o_rt_b,
    output logic                          o_x_valid_a,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_x_pc_a,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_x_insn_a,
    output logic [lc4_pkg::LC4_REG_W-1:0]  o_x_rd_a,
    output logic                          o_x_we_a,
    output logic                          o_x_valid_b,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_x_pc_b,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_x_insn_b,
    output logic [lc4_pkg::LC4_REG_W-1:0]  o_x_rd_b,
    output logic                          o_x_we_b
);
    import lc4_pkg::*;

    logic [LC4_WORD_W-1:0] pc_q;
    logic                  d_valid_a, d_valid_b;
    logic [LC4_WORD_W-1:0] d_pc_a, d_pc_b;
    lc4_insn_u             d_insn_a, d_insn_b;
    logic                  we_a, we_b;
    logic                  split;   // B depends on A, issue A alone

    // true for every kept instruction that produces a register result
    function automatic logic writes_rd(input lc4_insn_u insn);
        case (insn.r.opcode)
            LC4_OP_ARITH: return insn.i.imm ||
                                 (insn.r.sub inside {LC4_SUB_ADD, LC4_SUB_MUL, LC4_SUB_SUB});
            LC4_OP_LOGIC: return 1'b1;
            LC4_OP_CONST: return 1'b1;
            default:      return 1'b0;
        endcase
    endfunction

    function automatic logic reads_reg(input lc4_insn_u insn, input logic [LC4_REG_W-1:0] sel);
        logic rs_re;
        logic rt_re;
        rs_re = writes_rd(insn) && (insn.r.opcode != LC4_OP_CONST);
        rt_re = rs_re && !insn.i.imm &&
                !(insn.r.opcode == LC4_OP_LOGIC && insn.r.sub == LC4_SUB_NOT);
        return (rs_re && insn.r.rs == sel) || (rt_re && insn.r.rt == sel);
    endfunction

    assign we_a  = d_valid_a && writes_rd(d_insn_a);
    assign we_b  = d_valid_b && writes_rd(d_insn_b);
    assign split = we_a && d_valid_b && reads_reg(d_insn_b, d_insn_a.r.rd);

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q      <= LC4_RESET_PC;
            d_valid_a <= 1'b0;
            d_valid_b <= 1'b0;
        end else begin
            pc_q      <= split ? pc_q + 16'd1 : pc_q + 16'd2;
            d_valid_a <= 1'b1;   // no squash source, every fetched word is live
            d_valid_b <= 1'b1;
        end
    end

    always_ff @(posedge gwe) begin
        if (split) begin
            // held B becomes the older slot, the word fetched at pc follows it
            d_insn_a <= d_insn_b;
            d_pc_a   <= d_pc_b;
            d_insn_b <= i_insn_a;
            d_pc_b   <= pc_q;
        end else begin
            d_insn_a <= i_insn_a;
            d_pc_a   <= pc_q;
            d_insn_b <= i_insn_b;
            d_pc_b   <= pc_q + 16'd1;
        end
    end

    assign o_fetch_pc = pc_q;

    // register file read selectors, operands are captured with the slot
    assign o_rs_a = d_insn_a.r.rs;
    assign o_rt_a = d_insn_a.r.rt;
    assign o_rs_b = d_insn_b.r.rs;
    assign o_rt_b = d_insn_b.r.rt;

    assign o_x_valid_a = d_valid_a;
    assign o_x_pc_a    = d_pc_a;
    assign o_x_insn_a  = d_insn_a;
    assign o_x_rd_a    = d_insn_a.r.rd;
    assign o_x_we_a    = we_a;

    assign o_x_valid_b = d_valid_b && !split;
    assign o_x_pc_b    = d_pc_b;
    assign o_x_insn_b  = d_insn_b;
    assign o_x_rd_b    = d_insn_b.r.rd;
    assign o_x_we_b    = we_b && !split;

    // same-cycle A result is not on any bypass path, so B must never need it
    a_pair_independent: assert property (@(posedge gwe) disable iff (!i_arst_n)
        (o_x_we_a && o_x_we_b && d_insn_b.r.opcode != LC4_OP_CONST) |->
            (d_insn_b.r.rs != o_x_rd_a) &&
            (d_insn_b.i.imm || d_insn_b.r.rt != o_x_rd_a ||
             (d_insn_b.r.opcode == LC4_OP_LOGIC && d_insn_b.r.sub == LC4_SUB_NOT)));

endmodule

/* src/lc4_lane.sv */
//////////////////////////////////////////////////////////////////////
// one issue lane: execute, memory and writeback registers
// operands are bypassed youngest first: mem B, mem A, wb B, wb A,
// then the value read from the register file in decode
// no loads, so the memory stage only carries the ALU result along
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lc4_lane (
    input  logic                          gwe,
    input  logic                          i_arst_n,
    input  logic                          i_x_valid,
    input  logic [lc4_pkg::LC4_WORD_W-1:0] i_x_pc,
    input  logic [lc4_pkg::LC4_WORD_W-1:0] i_x_insn,
    input  logic [lc4_pkg::LC4_REG_W-1:0]  i_x_rd,
    input  logic                          i_x_we,
    input  logic [lc4_pkg::LC4_WORD_W-1:0] i_rs_data,
    input  logic [lc4_pkg::LC4_WORD_W-1:0] i_rt_data,
    input  logic                          i_mb_we,
    input  logic [lc4_pkg::LC4_REG_W-1:0]  i_mb_rd,
    input  logic [lc4_pkg::LC4_WORD_W-1:0] i_mb_data,
    input  logic                          i_ma_we,
    input  logic [lc4_pkg::LC4_REG_W-1:0]  i_ma_rd,
    input  logic [lc4_pkg::LC4_WORD_W-1:0] i_ma_data,
    input  logic                          i_wb_we,
    input  logic [lc4_pkg::LC4_REG_W-1:0]  i_wb_rd,
    input  logic [lc4_pkg::LC4_WORD_W-1:0] i_wb_data,
    input  logic                          i_wa_we,
    input  logic [lc4_pkg::LC4_REG_W-1:0]  i_wa_rd,
    input  logic [lc4_pkg::LC4_WORD_W-1:0] i_wa_data,
    output logic                          o_m_we,
    output logic [lc4_pkg::LC4_REG_W-1:0]  o_m_rd,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_m_data,
    output logic                          o_w_valid,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_w_pc,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_w_insn,
    output logic                          o_w_we,
    output logic [lc4_pkg::LC4_REG_W-1:0]  o_w_rd,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_w_data
);
    import lc4_pkg::*;

    logic                  x_valid, x_we;
    logic [LC4_WORD_W-1:0] x_pc, x_rs_data, x_rt_data;
    lc4_insn_u             x_insn;
    logic [LC4_REG_W-1:0]  x_rd;
    logic [LC4_WORD_W-1:0] rs_val, rt_val, alu_result;

    logic                  m_valid, m_we;
    logic [LC4_WORD_W-1:0] m_pc, m_insn, m_data;
    logic [LC4_REG_W-1:0]  m_rd;

    // newest producer of sel wins, otherwise the decode-stage read
    function automatic logic [LC4_WORD_W-1:0] pick(input logic [LC4_REG_W-1:0] sel,
                                                   input logic [LC4_WORD_W-1:0] rf_val);
        if (i_mb_we && i_mb_rd == sel)      return i_mb_data;
        else if (i_ma_we && i_ma_rd == sel) return i_ma_data;
        else if (i_wb_we && i_wb_rd == sel) return i_wb_data;
        else if (i_wa_we && i_wa_rd == sel) return i_wa_data;
        return rf_val;
    endfunction

    assign rs_val = pick(x_insn.r.rs, x_rs_data);
    assign rt_val = pick(x_insn.r.rt, x_rt_data);   // unused by imm/CONST forms, harmless

    lc4_alu u_alu (
        .i_insn    (x_insn),
        .i_rs_data (rs_val),
        .i_rt_data (rt_val),
        .o_result  (alu_result)
    );

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_valid   <= 1'b0;
            x_we      <= 1'b0;
            m_valid   <= 1'b0;
            m_we      <= 1'b0;
            o_w_valid <= 1'b0;
            o_w_we    <= 1'b0;
        end else begin
            x_valid   <= i_x_valid;
            x_we      <= i_x_we;
            m_valid   <= x_valid;
            m_we      <= x_we;
            o_w_valid <= m_valid;
            o_w_we    <= m_we;
        end
    end

    always_ff @(posedge gwe) begin
        x_pc      <= i_x_pc;
        x_insn    <= i_x_insn;
        x_rd      <= i_x_rd;
        x_rs_data <= i_rs_data;
        x_rt_data <= i_rt_data;
        m_pc      <= x_pc;
        m_insn    <= x_insn;
        m_rd      <= x_rd;
        m_data    <= alu_result;
        o_w_pc    <= m_pc;
        o_w_insn  <= m_insn;
        o_w_rd    <= m_rd;
        o_w_data  <= m_data;
    end

    assign o_m_we   = m_we;
    assign o_m_rd   = m_rd;
    assign o_m_data = m_data;

    // a bubble must never write, whatever the issue unit sent down
    a_we_needs_valid: assert property (@(posedge gwe) disable iff (!i_arst_n)
        (!x_valid -> !x_we) && (!m_valid -> !m_we) && (!o_w_valid -> !o_w_we));

endmodule

/* src/lc4_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared widths, opcodes and instruction views of the dual-issue LC4
// pipeline. only the ALU subset is decoded: ADD MUL SUB, AND NOT OR
// XOR, both immediate forms, CONST and the all-zero NOP
// any other opcode or sub-opcode (DIV included) behaves as a NOP
//////////////////////////////////////////////////////////////////////

package lc4_pkg;

    localparam int LC4_WORD_W   = 16;
    localparam int LC4_REG_W    = 3;
    localparam int LC4_NUM_REGS = 8;

    localparam logic [LC4_WORD_W-1:0] LC4_RESET_PC = 16'h8200;

    localparam logic [3:0] LC4_OP_NOP   = 4'b0000;
    localparam logic [3:0] LC4_OP_ARITH = 4'b0001;
    localparam logic [3:0] LC4_OP_LOGIC = 4'b0101;
    localparam logic [3:0] LC4_OP_CONST = 4'b1001;

    // sub-opcodes live in insn[5:3], bit 5 set means the immediate form
    localparam logic [2:0] LC4_SUB_ADD = 3'b000;
    localparam logic [2:0] LC4_SUB_MUL = 3'b001;
    localparam logic [2:0] LC4_SUB_SUB = 3'b010;
    localparam logic [2:0] LC4_SUB_AND = 3'b000;
    localparam logic [2:0] LC4_SUB_NOT = 3'b001;
    localparam logic [2:0] LC4_SUB_OR  = 3'b010;
    localparam logic [2:0] LC4_SUB_XOR = 3'b011;

    typedef struct packed {
        logic [3:0]           opcode;
        logic [LC4_REG_W-1:0] rd;
        logic [LC4_REG_W-1:0] rs;
        logic [2:0]           sub;
        logic [LC4_REG_W-1:0] rt;
    } lc4_rform_t;

    typedef struct packed {
        logic [3:0]           opcode;
        logic [LC4_REG_W-1:0] rd;
        logic [LC4_REG_W-1:0] rs;
        logic                 imm;   // immediate flag, insn[5]
        logic [4:0]           imm5;
    } lc4_iform_t;

    typedef struct packed {
        logic [3:0]           opcode;
        logic [LC4_REG_W-1:0] rd;
        logic [8:0]           imm9;
    } lc4_cform_t;

    // one instruction word, three ways of reading it
    typedef union packed {
        lc4_rform_t r;
        lc4_iform_t i;
        lc4_cform_t c;
    } lc4_insn_u;

endpackage

/* src/lc4_regfile.sv */
//////////////////////////////////////////////////////////////////////
// eight registers, four read ports, two write ports
// reads are write-through, port B wins when both write one register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lc4_regfile (
    input  logic                          gwe,
    input  logic                          i_arst_n,
    input  logic [lc4_pkg::LC4_REG_W-1:0]  i_rs_a,
    input  logic [lc4_pkg::LC4_REG_W-1:0]  i_rt_a,
    input  logic [lc4_pkg::LC4_REG_W-1:0]  i_rs_b,
    input  logic [lc4_pkg::LC4_REG_W-1:0]  i_rt_b,
    input  logic                          i_we_a,
    input  logic [lc4_pkg::LC4_REG_W-1:0]  i_rd_a,
    input  logic [lc4_pkg::LC4_WORD_W-1:0] i_wdata_a,
    input  logic                          i_we_b,
    input  logic [lc4_pkg::LC4_REG_W-1:0]  i_rd_b,
    input  logic [lc4_pkg::LC4_WORD_W-1:0] i_wdata_b,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_rs_data_a,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_rt_data_a,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_rs_data_b,
    output logic [lc4_pkg::LC4_WORD_W-1:0] o_rt_data_b
);
    import lc4_pkg::*;

    logic [LC4_WORD_W-1:0] regs [LC4_NUM_REGS];

    // same priority as the write below, B is the younger instruction
    function automatic logic [LC4_WORD_W-1:0] rd_port(input logic [LC4_REG_W-1:0] sel);
        if (i_we_b && i_rd_b == sel)      return i_wdata_b;
        else if (i_we_a && i_rd_a == sel) return i_wdata_a;
        return regs[sel];
    endfunction

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < LC4_NUM_REGS; i++) regs[i] <= '0;
        end else begin
            if (i_we_a) regs[i_rd_a] <= i_wdata_a;
            if (i_we_b) regs[i_rd_b] <= i_wdata_b;   // later assignment wins
        end
    end

    assign o_rs_data_a = rd_port(i_rs_a);
    assign o_rt_data_a = rd_port(i_rt_a);
    assign o_rs_data_b = rd_port(i_rs_b);
    assign o_rt_data_b = rd_port(i_rt_b);

    a_wdata_known: assert property (@(posedge gwe) disable iff (!i_arst_n)
        (i_we_a |-> !$isunknown(i_wdata_a)) and (i_we_b |-> !$isunknown(i_wdata_b)));

endmodule

/* tests/lc4_retire_checker.sv */
//////////////////////////////////////////////////////////////////////
// watches the retire ports and replays each retirement on a model
// register file. reads the program through tb_lc4_dual.imem and
// tb_lc4_dual.prog_len, words past the program count as NOP
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lc4_retire_checker (
    input  logic        gwe,
    input  logic        i_arst_n,
    input  logic [15:0] i_cur_pc,
    input  logic        i_valid_a,
    input  logic [15:0] i_pc_a,
    input  logic [15:0] i_insn_a,
    input  logic        i_we_a,
    input  logic [2:0]  i_wsel_a,
    input  logic [15:0] i_data_a,
    input  logic        i_valid_b,
    input  logic [15:0] i_pc_b,
    input  logic [15:0] i_insn_b,
    input  logic        i_we_b,
    input  logic [2:0]  i_wsel_b,
    input  logic [15:0] i_data_b,
    output int          o_retired,
    output int          o_errors
);
    import lc4_pkg::*;

    logic [15:0] model [8];
    logic [15:0] exp_pc;
    int          since_rst;

    // expected result of one instruction, straight from the ISA rules
    function automatic void ref_exec(input lc4_insn_u w, input logic [15:0] a,
                                     input logic [15:0] b, output logic we,
                                     output logic [15:0] val);
        logic [15:0] sx5;
        sx5 = {{11{w.i.imm5[4]}}, w.i.imm5};
        we  = 1'b1;
        val = 16'h0;
        if (w.r.opcode == 4'h1 && w.i.imm) val = a + sx5;
        else if (w.r.opcode == 4'h1 && w.r.sub == 3'd0) val = a + b;
        else if (w.r.opcode == 4'h1 && w.r.sub == 3'd1) val = a * b;
        else if (w.r.opcode == 4'h1 && w.r.sub == 3'd2) val = a - b;
        else if (w.r.opcode == 4'h5 && w.i.imm) val = a & sx5;
        else if (w.r.opcode == 4'h5 && w.r.sub == 3'd0) val = a & b;
        else if (w.r.opcode == 4'h5 && w.r.sub == 3'd1) val = ~a;
        else if (w.r.opcode == 4'h5 && w.r.sub == 3'd2) val = a | b;
        else if (w.r.opcode == 4'h5 && w.r.sub == 3'd3) val = a ^ b;
        else if (w.r.opcode == 4'h9) val = {{7{w.c.imm9[8]}}, w.c.imm9};
        else we = 1'b0;   // NOP, DIV and unknown opcodes
    endfunction

    task automatic compare_field(input string name, input logic [15:0] exp_v,
                                 input logic [15:0] act_v);
        if (exp_v !== act_v) begin
            $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
            o_errors++;
        end
    endtask

    task automatic retire_one(input string lane, input logic [15:0] pc,
                              input logic [15:0] insn, input logic we,
                              input logic [2:0] wsel, input logic [15:0] data);
        int          idx;
        logic [15:0] word;
        lc4_insn_u   w;
        logic        exp_we;
        logic [15:0] exp_val;
        idx  = int'(exp_pc - LC4_RESET_PC);
        word = (idx < tb_lc4_dual.prog_len) ? tb_lc4_dual.imem[idx] : 16'h0000;
        w    = word;
        ref_exec(w, model[w.r.rs], model[w.r.rt], exp_we, exp_val);
        compare_field({"o_wb_pc_", lane}, exp_pc, pc);
        compare_field({"o_wb_insn_", lane}, word, insn);
        compare_field({"o_wb_we_", lane}, 16'(exp_we), 16'(we));
        if (exp_we) begin
            compare_field({"o_wb_wsel_", lane}, 16'(w.r.rd), 16'(wsel));
            compare_field({"o_wb_data_", lane}, exp_val, data);
            model[w.r.rd] = exp_val;
        end
        exp_pc = exp_pc + 16'd1;
        o_retired++;
    endtask

    initial begin
        o_retired = 0;
        o_errors  = 0;
    end

    // sample away from the active edge
    always @(negedge gwe) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 8; i++) model[i] = 16'h0;
            exp_pc    = LC4_RESET_PC;
            o_retired = 0;
            since_rst = 0;
            compare_field("o_cur_pc", LC4_RESET_PC, i_cur_pc);
        end else begin
            since_rst++;
        end
        if (!i_arst_n || since_rst <= 2) begin
            if (i_valid_a || i_valid_b || i_we_a || i_we_b) begin
                $display("Error at %0t: retire port active during or right after reset", $time);
                o_errors++;
            end
        end else begin
            if (i_valid_a) retire_one("a", i_pc_a, i_insn_a, i_we_a, i_wsel_a, i_data_a);
            if (i_valid_b) retire_one("b", i_pc_b, i_insn_b, i_we_b, i_wsel_b, i_data_b);
        end
    end

endmodule

/* tests/tb_lc4_dual.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the dual-issue LC4 pipeline
// instruction memory is modelled here and answers o_cur_pc at once
// each test resets the DUT, then waits for its program to retire
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_lc4_dual;
    import lc4_pkg::*;

    localparam int MEM_WORDS = 512;
    localparam int NUM_TESTS = 5;
    localparam int TOTAL_INSNS = 18 + 6 + 12 + 8 + 200;
    localparam int CYCLE_LIMIT = 2 * TOTAL_INSNS + 20 * NUM_TESTS;

    logic        gwe = 1'b0;
    logic        i_arst_n;
    logic [15:0] i_cur_insn_a, i_cur_insn_b;
    logic [15:0] o_cur_pc;
    logic        o_wb_valid_a, o_wb_we_a, o_wb_valid_b, o_wb_we_b;
    logic [15:0] o_wb_pc_a, o_wb_insn_a, o_wb_data_a;
    logic [15:0] o_wb_pc_b, o_wb_insn_b, o_wb_data_b;
    logic [2:0]  o_wb_wsel_a, o_wb_wsel_b;

    logic [15:0] imem [MEM_WORDS];
    int          prog_len;
    int          retired, errors, cycles, passed, failed;
    logic [31:0] lcg_state;
    int          idx_a, idx_b;

    always #20 gwe = ~gwe;

    // combinational memory, nothing beyond the program
    always @* begin
        idx_a = int'(o_cur_pc - LC4_RESET_PC);
        idx_b = idx_a + 1;
        i_cur_insn_a = (idx_a >= 0 && idx_a < prog_len) ? imem[idx_a] : 16'h0000;
        i_cur_insn_b = (idx_b >= 0 && idx_b < prog_len) ? imem[idx_b] : 16'h0000;
    end

    lc4_dual_top u_lc4_dual_top (.*);

    lc4_retire_checker u_checker (
        .gwe, .i_arst_n, .i_cur_pc (o_cur_pc),
        .i_valid_a (o_wb_valid_a), .i_pc_a (o_wb_pc_a), .i_insn_a (o_wb_insn_a),
        .i_we_a (o_wb_we_a), .i_wsel_a (o_wb_wsel_a), .i_data_a (o_wb_data_a),
        .i_valid_b (o_wb_valid_b), .i_pc_b (o_wb_pc_b), .i_insn_b (o_wb_insn_b),
        .i_we_b (o_wb_we_b), .i_wsel_b (o_wb_wsel_b), .i_data_b (o_wb_data_b),
        .o_retired (retired), .o_errors (errors)
    );

    always @(posedge gwe) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: program did not retire within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic logic [15:0] enc_rr(input logic [3:0] op, input int rd, input int rs,
                                           input logic [2:0] sub, input int rt);
        return {op, 3'(rd), 3'(rs), sub, 3'(rt)};
    endfunction

    function automatic logic [15:0] enc_imm(input logic [3:0] op, input int rd, input int rs,
                                            input logic [4:0] imm5);
        return {op, 3'(rd), 3'(rs), 1'b1, imm5};
    endfunction

    function automatic logic [15:0] enc_const(input int rd, input logic [8:0] imm9);
        return {LC4_OP_CONST, 3'(rd), imm9};
    endfunction

    task automatic put(input logic [15:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    // reset, load while held, release and wait for every instruction
    task automatic run_test(input string name, input int which);
        int err0;
        @(posedge gwe) i_arst_n <= 1'b0;
        prog_len = 0;
        for (int i = 0; i < MEM_WORDS; i++) imem[i] = 16'h0000;
        case (which)
            1: begin   // independent pairs of every op
                for (int r = 0; r < 8; r++) put(enc_const(r, 9'(37 * r + 300)));
                put(enc_rr(LC4_OP_ARITH, 0, 1, LC4_SUB_ADD, 2));
                put(enc_rr(LC4_OP_ARITH, 3, 4, LC4_SUB_MUL, 5));
                put(enc_rr(LC4_OP_ARITH, 6, 1, LC4_SUB_SUB, 2));
                put(enc_imm(LC4_OP_ARITH, 7, 5, 5'h1d));
                put(enc_rr(LC4_OP_LOGIC, 1, 2, LC4_SUB_AND, 4));
                put(enc_rr(LC4_OP_LOGIC, 2, 5, LC4_SUB_NOT, 0));
                put(enc_rr(LC4_OP_LOGIC, 4, 6, LC4_SUB_OR, 7));
                put(enc_rr(LC4_OP_LOGIC, 5, 3, LC4_SUB_XOR, 0));
                put(enc_imm(LC4_OP_LOGIC, 6, 4, 5'h0f));
                put(16'h0000);
            end
            2: begin   // B reads A's destination in every pair
                put(enc_const(1, 9'd5));
                put(enc_rr(LC4_OP_ARITH, 2, 1, LC4_SUB_ADD, 1));
                put(enc_imm(LC4_OP_ARITH, 3, 2, 5'd4));
                put(enc_rr(LC4_OP_ARITH, 4, 3, LC4_SUB_MUL, 2));
                put(enc_rr(LC4_OP_LOGIC, 5, 4, LC4_SUB_NOT, 0));
                put(enc_rr(LC4_OP_LOGIC, 6, 5, LC4_SUB_XOR, 4));
            end
            3: begin   // chains across consecutive pairs
                for (int k = 0; k < 3; k++) begin
                    put(enc_imm(LC4_OP_ARITH, 1, 1, 5'd3));
                    put(enc_imm(LC4_OP_ARITH, 2, 2, 5'h1f));
                    put(enc_rr(LC4_OP_ARITH, 3, 1, LC4_SUB_ADD, 2));
                    put(enc_rr(LC4_OP_ARITH, 4, 2, LC4_SUB_SUB, 1));
                end
            end
            4: begin   // both lanes write r3, B must win
                put(enc_const(3, 9'd7));
                put(enc_const(3, 9'h1fe));
                put(enc_rr(LC4_OP_ARITH, 4, 3, LC4_SUB_ADD, 3));
                put(16'h0000);
                put(16'h0000);
                put(16'h0000);
                put(enc_rr(LC4_OP_LOGIC, 5, 3, LC4_SUB_OR, 0));
                put(16'h0000);
            end
            default: begin
                for (int n = 0; n < 200; n++) begin
                    case (lcg_next() % 11)
                        0: put(enc_rr(LC4_OP_ARITH, lcg_next(), lcg_next(), 3'd0, lcg_next()));
                        1: put(enc_rr(LC4_OP_ARITH, lcg_next(), lcg_next(), 3'd1, lcg_next()));
                        2: put(enc_rr(LC4_OP_ARITH, lcg_next(), lcg_next(), 3'd2, lcg_next()));
                        3: put(enc_imm(LC4_OP_ARITH, lcg_next(), lcg_next(), 5'(lcg_next())));
                        4: put(enc_rr(LC4_OP_LOGIC, lcg_next(), lcg_next(), 3'd0, lcg_next()));
                        5: put(enc_rr(LC4_OP_LOGIC, lcg_next(), lcg_next(), 3'd1, 0));
                        6: put(enc_rr(LC4_OP_LOGIC, lcg_next(), lcg_next(), 3'd2, lcg_next()));
                        7: put(enc_rr(LC4_OP_LOGIC, lcg_next(), lcg_next(), 3'd3, lcg_next()));
                        8: put(enc_imm(LC4_OP_LOGIC, lcg_next(), lcg_next(), 5'(lcg_next())));
                        9: put(enc_const(lcg_next(), 9'(lcg_next())));
                        default: put(16'h0000);
                    endcase
                end
            end
        endcase
        err0 = errors;
        repeat (10) @(posedge gwe);
        i_arst_n <= 1'b1;
        @(posedge gwe);
        while (retired < prog_len) @(posedge gwe);
        if (errors == err0) begin
            $display("test %s passed, %0d instructions retired", name, retired);
            passed++;
        end else begin
            $display("test %s failed, %0d errors", name, errors - err0);
            failed++;
        end
    endtask

    initial begin
        i_arst_n  = 1'b0;
        prog_len  = 0;
        cycles    = 0;
        passed    = 0;
        failed    = 0;
        lcg_state = 32'd84313;
        for (int i = 0; i < MEM_WORDS; i++) imem[i] = 16'h0000;
        run_test("independent_pairs", 1);
        run_test("pair_split", 2);
        run_test("bypass_chains", 3);
        run_test("same_dest_pair", 4);
        run_test("random_200", 5);
        $display("tests passed %0d, failed %0d, check errors %0d", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
